// ==== hw/ret_pred_pkg.sv ====
package ret_pred_pkg;

    // sizing
    localparam int ADDR_BITS  = 32;
    localparam int SET_NUM    = 8;
    localparam int INDEX_BITS = 3;
    localparam int TAG_BITS   = 27;
    localparam int WAYS       = 2;
    localparam int RAS_DEPTH  = 8;

    // stack pointer and occupancy widths
    localparam int RAS_PTR_BITS = $clog2(RAS_DEPTH);
    localparam int RAS_CNT_BITS = $clog2(RAS_DEPTH + 1);

    typedef logic [ADDR_BITS-1:0]  addr_t;
    typedef logic [TAG_BITS-1:0]   tag_t;
    typedef logic [INDEX_BITS-1:0] index_t;

    // one way of the table: valid plus tag
    typedef struct packed {
        logic valid;
        tag_t tag;
    } meta_t;

    // RAM word, both ways of one set
    typedef meta_t [WAYS-1:0] meta_set_t;

    typedef enum logic [1:0] {
        EX_NONE,
        EX_CALL,
        EX_RET
    } exec_kind_e;

    typedef struct packed {
        exec_kind_e kind;
        addr_t      pc;
    } exec_upd_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
    } fetch_req_t;

    typedef struct packed {
        logic  hit;
        logic  hit_pc;
        logic  hit_pcp4;
        logic  target_valid;
        addr_t target;
    } pred_t;

    typedef enum logic {
        ST_INIT,
        ST_RUN
    } rpct_state_e;

    // word address split, index in bits 4..2 and tag above it
    function automatic tag_t get_tag(addr_t addr);
        return addr[ADDR_BITS-1:INDEX_BITS+2];
    endfunction

    function automatic index_t get_index(addr_t addr);
        return addr[INDEX_BITS+1:2];
    endfunction

endpackage

// ==== hw/lutram_dual_port.sv ====
`timescale 1ns/1ps

// distributed RAM, one read/write port and one read-only port
module lutram_dual_port
    import ret_pred_pkg::*;
(
    input  logic      clk,

    // port a, read/write
    input  logic      wr_en,
    input  index_t    addr_a,
    input  meta_set_t wdata,
    output meta_set_t rdata_a,

    // port b, read only
    input  index_t    addr_b,
    output meta_set_t rdata_b
);

    meta_set_t mem [SET_NUM];

    // synchronous write through port a
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[addr_a] <= wdata;
        end
    end

    // both reads are asynchronous
    // a write shows up on the read ports from the next cycle
    assign rdata_a = mem[addr_a];
    assign rdata_b = mem[addr_b];

endmodule

// ==== hw/rpct.sv ====
`timescale 1ns/1ps

// return-PC cache table, 8 sets x 2 ways
module rpct
    import ret_pred_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  fetch_req_t fetch,
    input  exec_upd_t  exec_upd,
    output logic       hit_pc,
    output logic       hit_pcp4,
    output logic       ready
);

    rpct_state_e state_q;
    index_t      sweep_cnt;
    logic        sweeping;

    // one bit per set, names the victim way
    logic [SET_NUM-1:0] plru_q;

    addr_t     pc_p4;
    index_t    idx_pc;
    index_t    idx_pcp4;
    index_t    idx_ex;
    tag_t      tag_ex;
    meta_set_t meta_pc;
    meta_set_t meta_pcp4;
    meta_set_t meta_ex;

    logic [WAYS-1:0] match_pc;
    logic [WAYS-1:0] match_pcp4;
    logic [WAYS-1:0] match_ex;
    logic            way_pc;
    logic            way_pcp4;

    logic      upd_en;
    logic      way_sel;
    meta_set_t meta_new;

    logic      touch_en;
    index_t    touch_set;
    logic      touch_way;

    logic      ram_we;
    index_t    ram_addr;
    meta_set_t ram_wdata;

    // per-way hit vector for one set word
    function automatic logic [WAYS-1:0] match_vec(meta_set_t s, tag_t t);
        logic [WAYS-1:0] m;
        for (int w = 0; w < WAYS; w++) begin
            m[w] = s[w].valid && (s[w].tag == t);
        end
        return m;
    endfunction

    // init sweep, one set per cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= ST_INIT;
            sweep_cnt <= '0;
        end else if (state_q == ST_INIT) begin
            sweep_cnt <= sweep_cnt + 1'b1;
            if (sweep_cnt == index_t'(SET_NUM - 1)) begin
                state_q <= ST_RUN;
            end
        end
    end

    assign sweeping = (state_q == ST_INIT);
    assign ready    = (state_q == ST_RUN);

    // fetch lookup, pc and pc+4 each in its own set
    assign pc_p4    = fetch.pc + addr_t'(4);
    assign idx_pc   = get_index(fetch.pc);
    assign idx_pcp4 = get_index(pc_p4);

    assign match_pc   = match_vec(meta_pc, get_tag(fetch.pc));
    assign match_pcp4 = match_vec(meta_pcp4, get_tag(pc_p4));
    assign way_pc     = match_pc[1];
    assign way_pcp4   = match_pcp4[1];

    // table contents are meaningless until the sweep is done
    assign hit_pc   = fetch.valid && ready && (|match_pc);
    assign hit_pcp4 = fetch.valid && ready && (|match_pcp4);

    // pc slot wins when both slots hit
    assign touch_en  = hit_pc || hit_pcp4;
    assign touch_set = hit_pc ? idx_pc : idx_pcp4;
    assign touch_way = hit_pc ? way_pc : way_pcp4;

    // return install, read-modify-write of one set
    assign idx_ex   = get_index(exec_upd.pc);
    assign tag_ex   = get_tag(exec_upd.pc);
    assign upd_en   = ready && (exec_upd.kind == EX_RET);
    assign match_ex = match_vec(meta_ex, tag_ex);

    // reuse the way holding the tag, else the pLRU victim
    assign way_sel = (|match_ex) ? match_ex[1] : plru_q[idx_ex];

    always_comb begin
        meta_new                = meta_ex;
        meta_new[way_sel].valid = 1'b1;
        meta_new[way_sel].tag   = tag_ex;
    end

    // sweep owns the write port until ready
    assign ram_we    = sweeping || upd_en;
    assign ram_addr  = sweeping ? sweep_cnt : idx_ex;
    assign ram_wdata = sweeping ? meta_set_t'('0) : meta_new;

    // write after touch so a same-set install has priority
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            plru_q <= '0;
        end else begin
            if (touch_en) begin
                plru_q[touch_set] <= ~touch_way;
            end
            if (upd_en) begin
                plru_q[idx_ex] <= ~way_sel;
            end
        end
    end

    // copy serving the pc lookup and the update read
    lutram_dual_port meta_ram_lo (
        .clk     (clk),
        .wr_en   (ram_we),
        .addr_a  (ram_addr),
        .wdata   (ram_wdata),
        .rdata_a (meta_ex),
        .addr_b  (idx_pc),
        .rdata_b (meta_pc)
    );

    // mirror copy for the pc+4 lookup, its port a read is not needed
    lutram_dual_port meta_ram_hi (
        .clk     (clk),
        .wr_en   (ram_we),
        .addr_a  (ram_addr),
        .wdata   (ram_wdata),
        .rdata_a (),
        .addr_b  (idx_pcp4),
        .rdata_b (meta_pcp4)
    );

endmodule

// ==== hw/ras.sv ====
`timescale 1ns/1ps

// circular return address stack
module ras
    import ret_pred_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  exec_upd_t exec_upd,
    output addr_t     top,
    output logic      top_valid
);

    addr_t stack_q [RAS_DEPTH];

    // ptr is the next free slot, top sits one below
    logic [RAS_PTR_BITS-1:0] ptr_q;
    logic [RAS_PTR_BITS-1:0] top_ptr;
    logic [RAS_CNT_BITS-1:0] count_q;

    logic  push;
    logic  pop;
    logic  empty;
    logic  full;
    addr_t link_addr;

    assign push  = (exec_upd.kind == EX_CALL);
    assign pop   = (exec_upd.kind == EX_RET);
    assign empty = (count_q == '0);
    assign full  = (count_q == RAS_CNT_BITS'(RAS_DEPTH));

    // return lands after the delay slot
    assign link_addr = exec_upd.pc + addr_t'(8);

    // pointer and occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr_q   <= '0;
            count_q <= '0;
        end else if (push) begin
            // when full the pointer wraps onto the oldest entry
            ptr_q <= ptr_q + 1'b1;
            if (!full) begin
                count_q <= count_q + 1'b1;
            end
        end else if (pop && !empty) begin
            ptr_q   <= ptr_q - 1'b1;
            count_q <= count_q - 1'b1;
        end
    end

    // entries
    always_ff @(posedge clk) begin
        if (push) begin
            stack_q[ptr_q] <= link_addr;
        end
    end

    assign top_ptr   = ptr_q - 1'b1;
    assign top_valid = !empty;

    // empty stack reads as zero, not as a stale slot
    assign top = empty ? addr_t'(0) : stack_q[top_ptr];

endmodule

// ==== hw/ret_pred_unit.sv ====
`timescale 1ns/1ps

// return prediction for fetch, table of return PCs plus link stack
module ret_pred_unit
    import ret_pred_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  fetch_req_t fetch,
    input  exec_upd_t  exec_upd,
    output pred_t      pred,
    output logic       ready
);

    logic      hit_pc;
    logic      hit_pcp4;
    addr_t     top;
    logic      top_valid;
    exec_upd_t ras_upd;

    // execute updates are dropped during the sweep
    always_comb begin
        ras_upd = exec_upd;
        if (!ready) begin
            ras_upd.kind = EX_NONE;
        end
    end

    rpct rpct_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .fetch    (fetch),
        .exec_upd (exec_upd),
        .hit_pc   (hit_pc),
        .hit_pcp4 (hit_pcp4),
        .ready    (ready)
    );

    ras ras_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .exec_upd  (ras_upd),
        .top       (top),
        .top_valid (top_valid)
    );

    // target comes straight from the stack, hit or not
    always_comb begin
        pred.hit          = hit_pc | hit_pcp4;
        pred.hit_pc       = hit_pc;
        pred.hit_pcp4     = hit_pcp4;
        pred.target_valid = top_valid;
        pred.target       = top;
    end

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps

// clock and power-on reset for the testbench
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam real HALF_PERIOD_NS = 4.0;
    localparam int  RESET_CYCLES   = 3;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

    // release on a falling edge, clear of the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== tests/tb_ret_pred_unit.sv ====
`timescale 1ns/1ps

module tb_ret_pred_unit
    import ret_pred_pkg::*;
();

    localparam int RAND_CYCLES   = 400;
    localparam int READY_TIMEOUT = 64;
    localparam int RESET_TIMEOUT = 32;

    logic       clk;
    logic       rst_n;
    fetch_req_t fetch;
    exec_upd_t  exec_upd;
    pred_t      pred;
    logic       ready;

    int checks;
    int errors;
    int tests_run;
    int tests_failed;
    int test_err_base;

    logic [31:0] lfsr_q;
    logic        ready_seen;

    // reference state, table and link stack
    logic  m_valid [SET_NUM][WAYS];
    tag_t  m_tag   [SET_NUM][WAYS];
    logic  m_plru  [SET_NUM];
    addr_t m_stack [$];

    tb_clock_gen clock_gen_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    ret_pred_unit ret_pred_unit_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .fetch    (fetch),
        .exec_upd (exec_upd),
        .pred     (pred),
        .ready    (ready)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // small window so that random traffic actually hits and evicts
    function automatic addr_t rand_pc();
        return 32'h0000_6000 | (addr_t'(rand_bits(6)) << 2);
    endfunction

    function automatic int set_of(addr_t a);
        return int'(a[4:2]);
    endfunction

    function automatic tag_t tag_of(addr_t a);
        return a[31:5];
    endfunction

    function automatic int find_way(addr_t a);
        for (int w = 0; w < WAYS; w++) begin
            if (m_valid[set_of(a)][w] && m_tag[set_of(a)][w] == tag_of(a)) begin
                return w;
            end
        end
        return -1;
    endfunction

    function automatic pred_t ref_predict(fetch_req_t f);
        pred_t p;
        p = '0;
        p.hit_pc       = f.valid && (find_way(f.pc) >= 0);
        p.hit_pcp4     = f.valid && (find_way(f.pc + 32'd4) >= 0);
        p.hit          = p.hit_pc | p.hit_pcp4;
        p.target_valid = (m_stack.size() != 0);
        if (p.target_valid) begin
            p.target = m_stack[$];
        end
        return p;
    endfunction

    task automatic model_reset();
        for (int s = 0; s < SET_NUM; s++) begin
            m_plru[s] = 1'b0;
            for (int w = 0; w < WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_tag[s][w]   = '0;
            end
        end
        m_stack.delete();
    endtask

    task automatic model_advance(input fetch_req_t f, input exec_upd_t u);
        int w_pc;
        int w_p4;
        int w_ins;
        int s_ins;
        w_pc  = f.valid ? find_way(f.pc) : -1;
        w_p4  = f.valid ? find_way(f.pc + 32'd4) : -1;
        s_ins = set_of(u.pc);
        // victim picked from the bit before this cycle's touch
        w_ins = find_way(u.pc);
        if (w_ins < 0) begin
            w_ins = int'(m_plru[s_ins]);
        end
        if (w_pc >= 0) begin
            m_plru[set_of(f.pc)] = (w_pc == 0);
        end else if (w_p4 >= 0) begin
            m_plru[set_of(f.pc + 32'd4)] = (w_p4 == 0);
        end
        if (u.kind == EX_RET) begin
            m_valid[s_ins][w_ins] = 1'b1;
            m_tag[s_ins][w_ins]   = tag_of(u.pc);
            m_plru[s_ins]         = (w_ins == 0);
            if (m_stack.size() > 0) begin
                void'(m_stack.pop_back());
            end
        end else if (u.kind == EX_CALL) begin
            m_stack.push_back(u.pc + 32'd8);
            if (m_stack.size() > RAS_DEPTH) begin
                void'(m_stack.pop_front());
            end
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH t=%0t %s got=%0b exp=%0b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH t=%0t %s got=%08h exp=%08h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_int(input string name, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            $display("MISMATCH t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic timeout_abort(input string what);
        $display("timeout at t=%0t: %s", $time, what);
        $display("** FAIL **");
        $finish;
    endtask

    task automatic begin_test();
        test_err_base = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_err_base) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests_run, name,
                     errors - test_err_base);
        end
    endtask

    task automatic drive_idle();
        @(negedge clk);
        fetch    = '{valid: 1'b0, pc: '0};
        exec_upd = '{kind: EX_NONE, pc: '0};
    endtask

    // one update cycle, returns on the next falling edge with inputs idle
    task automatic send_update(input exec_kind_e kind, input addr_t pc);
        @(negedge clk);
        fetch    = '{valid: 1'b0, pc: '0};
        exec_upd = '{kind: kind, pc: pc};
        @(negedge clk);
        exec_upd = '{kind: EX_NONE, pc: '0};
    endtask

    task automatic probe_fetch(input addr_t pc, input logic exp_pc, input logic exp_p4);
        @(negedge clk);
        fetch    = '{valid: 1'b1, pc: pc};
        exec_upd = '{kind: EX_NONE, pc: '0};
        #2;
        check_bit("pred.hit_pc", pred.hit_pc, exp_pc);
        check_bit("pred.hit_pcp4", pred.hit_pcp4, exp_p4);
        check_bit("pred.hit", pred.hit, exp_pc | exp_p4);
    endtask

    task automatic check_stack(input logic exp_valid, input addr_t exp_target);
        #2;
        check_bit("pred.target_valid", pred.target_valid, exp_valid);
        if (exp_valid) begin
            check_addr("pred.target", pred.target, exp_target);
        end
    endtask

    // cycle by cycle comparison against the reference model
    always @(posedge clk) begin : compare_proc
        pred_t exp_pred;
        // once up, ready never drops again
        if (ready_seen) begin
            check_bit("ready", ready, 1'b1);
        end
        if (rst_n && ready) begin
            ready_seen = 1'b1;
            exp_pred = ref_predict(fetch);
            check_bit("pred.hit", pred.hit, exp_pred.hit);
            check_bit("pred.hit_pc", pred.hit_pc, exp_pred.hit_pc);
            check_bit("pred.hit_pcp4", pred.hit_pcp4, exp_pred.hit_pcp4);
            check_bit("pred.target_valid", pred.target_valid, exp_pred.target_valid);
            if (exp_pred.target_valid) begin
                check_addr("pred.target", pred.target, exp_pred.target);
            end
            model_advance(fetch, exec_upd);
        end
    end

    initial begin : stimulus
        int    cycles;
        int    victim;
        addr_t evict_pc;
        addr_t keep_pc;
        addr_t pa;
        addr_t pb;
        addr_t pc_c;
        fetch_req_t f;
        exec_upd_t  u;

        lfsr_q       = 32'h1d10;
        checks       = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        ready_seen   = 1'b0;
        // a call held during the sweep must be dropped
        fetch    = '{valid: 1'b1, pc: 32'h0000_0100};
        exec_upd = '{kind: EX_CALL, pc: 32'h0000_0200};
        model_reset();

        // 1: reset and sweep
        begin_test();
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            timeout_abort("reset never released");
        end
        cycles = 0;
        while (cycles < READY_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (ready) begin
                break;
            end
            check_bit("pred.hit", pred.hit, 1'b0);
            check_bit("pred.target_valid", pred.target_valid, 1'b0);
        end
        if (!ready) begin
            timeout_abort("ready did not rise after the reset sweep");
        end
        exec_upd = '{kind: EX_NONE, pc: '0};
        check_int("ready latency", cycles, SET_NUM);
        for (int i = 0; i < 4; i++) begin
            probe_fetch(32'h0000_0100 + addr_t'(i * 4), 1'b0, 1'b0);
            check_stack(1'b0, '0);
        end
        end_test("reset and sweep");

        // 2: learn and predict
        begin_test();
        send_update(EX_RET, 32'h0000_3010);
        probe_fetch(32'h0000_3010, 1'b1, 1'b0);
        probe_fetch(32'h0000_300c, 1'b0, 1'b1);
        // same set, other tag
        probe_fetch(32'h0000_5010, 1'b0, 1'b0);
        end_test("learn and predict");

        // 3: replacement in set 3
        begin_test();
        pa   = 32'h0000_400c;
        pb   = 32'h0000_402c;
        pc_c = 32'h0000_404c;
        send_update(EX_RET, pa);
        send_update(EX_RET, pb);
        probe_fetch(pa, 1'b1, 1'b0);
        drive_idle();
        victim   = int'(m_plru[set_of(pa)]);
        evict_pc = (m_tag[set_of(pa)][victim] == tag_of(pa)) ? pa : pb;
        keep_pc  = (evict_pc == pa) ? pb : pa;
        // the hit on pa steers the victim to pb
        check_addr("evicted entry", evict_pc, pb);
        send_update(EX_RET, pc_c);
        probe_fetch(evict_pc, 1'b0, 1'b0);
        probe_fetch(keep_pc, 1'b1, 1'b0);
        probe_fetch(pc_c, 1'b1, 1'b0);
        end_test("replacement");

        // 4: stack targets, overflow and empty pop
        begin_test();
        send_update(EX_RET, 32'h0000_7000);
        check_stack(1'b0, '0);
        for (int i = 0; i < RAS_DEPTH + 2; i++) begin
            send_update(EX_CALL, 32'h0000_8000 + addr_t'(i * 16));
            check_stack(1'b1, 32'h0000_8008 + addr_t'(i * 16));
        end
        // entries 2 to 9 survive the wrap
        for (int j = 1; j <= RAS_DEPTH; j++) begin
            send_update(EX_RET, 32'h0000_7000);
            if (j < RAS_DEPTH) begin
                check_stack(1'b1, 32'h0000_8008 + addr_t'((RAS_DEPTH + 1 - j) * 16));
            end else begin
                check_stack(1'b0, '0);
            end
        end
        send_update(EX_RET, 32'h0000_7000);
        check_stack(1'b0, '0);
        end_test("stack targets");

        // 5: random mix
        begin_test();
        for (int i = 0; i < RAND_CYCLES; i++) begin
            @(negedge clk);
            f.valid = (rand_bits(2) != 0);
            f.pc    = rand_pc();
            case (rand_bits(2))
                2'd1:    u.kind = EX_CALL;
                2'd2:    u.kind = EX_RET;
                default: u.kind = EX_NONE;
            endcase
            u.pc     = rand_pc();
            fetch    = f;
            exec_upd = u;
        end
        drive_idle();
        drive_idle();
        end_test("random mix");

        $display("tests=%0d failed=%0d checks=%0d errors=%0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== ret_pred.f ====
hw/ret_pred_pkg.sv
hw/lutram_dual_port.sv
hw/rpct.sv
hw/ras.sv
hw/ret_pred_unit.sv
tests/tb_clock_gen.sv
tests/tb_ret_pred_unit.sv
